/* logic/hazard_pkg.sv */
package hazard_pkg;

  // core widths
  localparam int xlen     = 32;
  localparam int num_regs = 32;
  localparam int reg_w    = 5;

  // completion buffer geometry, depth must stay a power of two
  localparam int cb_depth = 8;
  localparam int cb_idx_w = 3;

  // operand source select from decode
  // the first two read the register file, the others do not
  typedef enum logic [1:0] {
    rs_reg  = 2'd0,
    rs_fwd  = 2'd1,
    src_imm = 2'd2,
    src_pc  = 2'd3
  } src_sel_t;

  // exception causes reported at commit
  typedef struct packed {
    logic fault_insn;
    logic mal_insn;
    logic illegal_insn;
    logic fault_l;
    logic mal_l;
    logic fault_s;
    logic mal_s;
    logic breakpoint;
    logic env_m;
  } exc_flags_t;

  // instruction offered by decode for dispatch
  typedef struct packed {
    logic             valid;
    logic [reg_w-1:0] rs1;
    logic [reg_w-1:0] rs2;
    logic [reg_w-1:0] rd;
    logic             wen;
    src_sel_t         src_a_sel;
    src_sel_t         src_b_sel;
    logic             is_ls;
    logic [xlen-1:0]  pc;
  } decode_req_t;

  // writeback strobe from a functional unit
  typedef struct packed {
    logic                valid;
    logic [cb_idx_w-1:0] cb_idx;
    exc_flags_t          exc;
    logic [xlen-1:0]     badaddr_i;
    logic [xlen-1:0]     badaddr_d;
  } wb_t;

  // head entry of the completion buffer
  typedef struct packed {
    logic             valid;
    logic [reg_w-1:0] rd;
    logic             wen;
    logic [xlen-1:0]  pc;
    exc_flags_t       exc;
    logic [xlen-1:0]  badaddr;
  } commit_t;

  // payload held per buffer entry
  typedef struct packed {
    logic [reg_w-1:0] rd;
    logic             wen;
    logic [xlen-1:0]  pc;
    exc_flags_t       exc;
    logic [xlen-1:0]  badaddr;
  } cb_entry_t;

  // request towards the privilege block
  typedef struct packed {
    logic            trap;
    exc_flags_t      exc;
    logic [xlen-1:0] epc;
    logic [xlen-1:0] badaddr;
    logic            intr_taken;
  } priv_req_t;

  // fetch and decode control
  typedef struct packed {
    logic pc_en;
    logic stall_de;
    logic npc_sel;
    logic if_id_flush;
  } fetch_ctrl_t;

endpackage

/* logic/reg_scoreboard.sv */
`timescale 1ns/1ps

module reg_scoreboard
  import hazard_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        dispatch_fire,
  input  decode_req_t req,
  input  commit_t     commit,
  input  logic        flush,
  output logic        rs1_busy,
  output logic        rs2_busy,
  output logic        rd_busy
);

  // one bit per architectural register
  // a bit stays set while its result is in flight
  logic [num_regs-1:0] busy;
  logic [num_regs-1:0] set_mask;
  logic [num_regs-1:0] clr_mask;
  logic                set_en;
  logic                clr_en;

  // x0 is hardwired and never marked
  assign set_en = dispatch_fire & req.wen & (req.rd != '0);

  // only a clean retire frees the register
  // an excepting commit is followed by the flush anyway
  assign clr_en = commit.valid & commit.wen & (commit.exc == '0) & (commit.rd != '0);

  always_comb begin
    set_mask = '0;
    if (set_en) begin
      set_mask[req.rd] = 1'b1;
    end
  end

  always_comb begin
    clr_mask = '0;
    if (clr_en) begin
      clr_mask[commit.rd] = 1'b1;
    end
  end

  // flush drops every pending writer at once
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      busy <= '0;
    end else begin
      // set wins over clear so a new writer of the same reg keeps it busy
      busy <= (busy & ~clr_mask) | set_mask;
    end
  end

  // queries for the request sitting in decode
  assign rs1_busy = busy[req.rs1];
  assign rs2_busy = busy[req.rs2];
  assign rd_busy  = busy[req.rd];

  // the hazard unit holds back a second writer so dispatch must find rd free
  a_no_double_set: assert property (
    @(posedge clk) disable iff (!rst_n)
    set_en |-> !busy[req.rd]
  ) else $error("scoreboard: dispatch to busy rd %0d", req.rd);

endmodule

/* logic/completion_buffer.sv */
`timescale 1ns/1ps

module completion_buffer
  import hazard_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                dispatch_fire,
  input  decode_req_t         req,
  input  wb_t                 wb,
  input  logic                flush,
  output logic [cb_idx_w-1:0] dispatch_idx,
  output logic                full,
  output commit_t             commit
);

  // per entry control bits
  logic [cb_depth-1:0] ent_valid;
  logic [cb_depth-1:0] ent_done;

  // per entry payload
  cb_entry_t           ent_mem [cb_depth];

  // ring pointers and occupancy
  logic [cb_idx_w-1:0] head;
  logic [cb_idx_w-1:0] tail;
  logic [cb_idx_w:0]   count;

  logic                retire;
  logic [xlen-1:0]     wb_badaddr;

  // new entries go to the tail and units echo this index on writeback
  assign dispatch_idx = tail;

  // count needs one extra bit to tell full from empty
  assign full = (count == (cb_idx_w+1)'(cb_depth));

  // instruction faults report the fetch address and everything else the data address
  assign wb_badaddr = (wb.exc.fault_insn || wb.exc.mal_insn) ? wb.badaddr_i : wb.badaddr_d;

  // head is offered for commit as soon as its result is back
  assign commit.valid   = ent_valid[head] & ent_done[head];
  assign commit.rd      = ent_mem[head].rd;
  assign commit.wen     = ent_mem[head].wen;
  assign commit.pc      = ent_mem[head].pc;
  assign commit.exc     = ent_mem[head].exc;
  assign commit.badaddr = ent_mem[head].badaddr;

  // without back-pressure on commit the head always leaves on the next edge
  assign retire = commit.valid;

  // control state
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      ent_valid <= '0;
      ent_done  <= '0;
      head      <= '0;
      tail      <= '0;
      count     <= '0;
    end else begin
      // allocate at the tail
      if (dispatch_fire) begin
        ent_valid[tail] <= 1'b1;
        ent_done[tail]  <= 1'b0;
        tail            <= tail + 1'b1;
      end

      // out of order completion by index
      if (wb.valid) begin
        ent_done[wb.cb_idx] <= 1'b1;
      end

      // in order retire from the head
      if (retire) begin
        ent_valid[head] <= 1'b0;
        ent_done[head]  <= 1'b0;
        head            <= head + 1'b1;
      end

      unique case ({dispatch_fire, retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // payload captured at dispatch and at writeback
  always_ff @(posedge clk) begin
    if (dispatch_fire) begin
      ent_mem[tail].rd  <= req.rd;
      ent_mem[tail].wen <= req.wen;
      ent_mem[tail].pc  <= req.pc;
    end
    if (wb.valid) begin
      ent_mem[wb.cb_idx].exc     <= wb.exc;
      ent_mem[wb.cb_idx].badaddr <= wb_badaddr;
    end
  end

  // decode stalls on full so an allocate must always find room
  a_no_alloc_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    dispatch_fire |-> !full
  ) else $error("completion buffer: dispatch while full");

  // a unit may only complete something that was dispatched and not yet retired
  a_wb_live: assert property (
    @(posedge clk) disable iff (!rst_n)
    wb.valid |-> ent_valid[wb.cb_idx]
  ) else $error("completion buffer: writeback to idle entry %0d", wb.cb_idx);

endmodule

/* logic/ooo_hazard_unit.sv */
`timescale 1ns/1ps

module ooo_hazard_unit
  import hazard_pkg::*;
(
  input  decode_req_t req,
  input  logic        rs1_busy,
  input  logic        rs2_busy,
  input  logic        rd_busy,
  input  logic        cb_full,
  input  commit_t     commit,
  input  logic        busy_ls,
  input  logic        jump,
  input  logic        branch,
  input  logic        mispredict,
  input  logic        intr,
  output logic        dispatch_fire,
  output logic        flush,
  output fetch_ctrl_t fetch,
  output priv_req_t   priv
);

  logic rs1_hazard;
  logic rs2_hazard;
  logic rd_hazard;
  logic data_hazard;
  logic ls_hazard;
  logic stall;
  logic commit_exc;
  logic intr_taken;
  logic branch_jump;

  // operand a only matters when it reads a register
  always_comb begin
    unique case (req.src_a_sel)
      rs_reg, rs_fwd: rs1_hazard = rs1_busy;
      default:        rs1_hazard = 1'b0;
    endcase
  end

  // same for operand b
  always_comb begin
    unique case (req.src_b_sel)
      rs_reg, rs_fwd: rs2_hazard = rs2_busy;
      default:        rs2_hazard = 1'b0;
    endcase
  end

  // waw, an older writer of rd still in flight
  assign rd_hazard   = rd_busy & req.wen;
  assign data_hazard = rs1_hazard | rs2_hazard | rd_hazard;

  // memory ops wait for the load-store unit
  assign ls_hazard = req.is_ls & busy_ls;

  // an empty decode slot never holds fetch back
  assign stall = req.valid & (data_hazard | cb_full | ls_hazard);

  // allocate strobe for scoreboard and buffer
  assign dispatch_fire = req.valid & ~stall;

  // any cause flag on the retiring entry
  assign commit_exc = commit.valid & (commit.exc != '0);

  // interrupts only between clean commits
  assign intr_taken = intr & ~commit_exc;

  // trap or interrupt empties the whole window
  assign flush = commit_exc | intr_taken;

  // redirect from execute, the privilege vector wins over it
  assign branch_jump = jump | (branch & mispredict);

  assign fetch.pc_en       = ~stall;
  assign fetch.stall_de    = stall;
  assign fetch.npc_sel     = branch_jump & ~flush;
  assign fetch.if_id_flush = fetch.npc_sel | flush;

  // trap information straight from the head entry
  assign priv.trap       = commit_exc;
  assign priv.exc        = commit.valid ? commit.exc : '0;
  assign priv.epc        = commit.pc;
  assign priv.badaddr    = commit.badaddr;
  assign priv.intr_taken = intr_taken;

  // privilege block accepts one event per cycle
  always_comb begin
    a_trap_intr_excl: assert final (!(priv.trap && priv.intr_taken))
      else $error("hazard unit: trap and interrupt taken together");
  end

endmodule

/* logic/ooo_hazard_top.sv */
`timescale 1ns/1ps

module ooo_hazard_top
  import hazard_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  decode_req_t         req,
  input  wb_t                 wb,
  input  logic                busy_ls,
  input  logic                jump,
  input  logic                branch,
  input  logic                mispredict,
  input  logic                intr,
  output fetch_ctrl_t         fetch,
  output logic                dispatch_fire,
  output logic [cb_idx_w-1:0] dispatch_idx,
  output commit_t             commit,
  output priv_req_t           priv
);

  // scoreboard answers for the decode request
  logic rs1_busy;
  logic rs2_busy;
  logic rd_busy;

  // buffer status and the window flush
  logic cb_full;
  logic flush;

  reg_scoreboard u_reg_scoreboard (
    .clk           (clk),
    .rst_n         (rst_n),
    .dispatch_fire (dispatch_fire),
    .req           (req),
    .commit        (commit),
    .flush         (flush),
    .rs1_busy      (rs1_busy),
    .rs2_busy      (rs2_busy),
    .rd_busy       (rd_busy)
  );

  completion_buffer u_completion_buffer (
    .clk           (clk),
    .rst_n         (rst_n),
    .dispatch_fire (dispatch_fire),
    .req           (req),
    .wb            (wb),
    .flush         (flush),
    .dispatch_idx  (dispatch_idx),
    .full          (cb_full),
    .commit        (commit)
  );

  ooo_hazard_unit u_ooo_hazard_unit (
    .req           (req),
    .rs1_busy      (rs1_busy),
    .rs2_busy      (rs2_busy),
    .rd_busy       (rd_busy),
    .cb_full       (cb_full),
    .commit        (commit),
    .busy_ls       (busy_ls),
    .jump          (jump),
    .branch        (branch),
    .mispredict    (mispredict),
    .intr          (intr),
    .dispatch_fire (dispatch_fire),
    .flush         (flush),
    .fetch         (fetch),
    .priv          (priv)
  );

endmodule

/* bench/hazard_tb.sv */
`timescale 1ns/1ps

module hazard_tb
  import hazard_pkg::*;
;

  // cycle budget per test
  // the watchdog fires after their sum
  localparam int t_reset  = 12;
  localparam int t_hazard = 40;
  localparam int t_fill   = 60;
  localparam int t_exc    = 20;
  localparam int t_intr   = 80;
  localparam int t_margin = 100;
  localparam int t_total  = t_reset + t_hazard + t_fill + t_exc + t_intr + t_margin;

  // one dispatched instruction as the model remembers it
  typedef struct packed {
    logic [xlen-1:0]     pc;
    logic [reg_w-1:0]    rd;
    logic                wen;
    logic [cb_idx_w-1:0] idx;
  } model_ent_t;

  logic clk;
  logic rst_n;
  decode_req_t req;
  wb_t wb;
  logic busy_ls;
  logic jump;
  logic branch;
  logic mispredict;
  logic intr;
  fetch_ctrl_t fetch;
  logic dispatch_fire;
  logic [cb_idx_w-1:0] dispatch_idx;
  commit_t commit;
  priv_req_t priv;

  // reference model state
  model_ent_t model_q[$];
  logic [num_regs-1:0] m_busy;
  logic [cb_depth-1:0] m_done;
  exc_flags_t m_exc [cb_depth];
  logic [xlen-1:0] m_bad [cb_depth];
  logic [cb_idx_w-1:0] m_tail;

  // expected responses of the DUT in the current cycle
  model_ent_t m_head;
  logic exp_full;
  logic exp_cvalid;
  logic exp_trap;
  logic exp_intr;
  logic exp_flush;
  logic exp_stall;
  logic exp_fire;
  logic exp_npc;
  logic exp_ifid;

  logic [cb_idx_w-1:0] fill_idx [cb_depth];
  int order [cb_depth];

  ooo_hazard_top u_ooo_hazard_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .req           (req),
    .wb            (wb),
    .busy_ls       (busy_ls),
    .jump          (jump),
    .branch        (branch),
    .mispredict    (mispredict),
    .intr          (intr),
    .fetch         (fetch),
    .dispatch_fire (dispatch_fire),
    .dispatch_idx  (dispatch_idx),
    .commit        (commit),
    .priv          (priv)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [xlen-1:0] exp_v,
                                 input logic [xlen-1:0] got_v);
    abort_run($sformatf("error at %0d ns: %s expected %h actual %h", $time, name, exp_v,
                        got_v));
  endtask

  // only the two register selects read the register file
  function automatic logic reads_reg(input src_sel_t s);
    return (s == rs_reg) || (s == rs_fwd);
  endfunction

  always_comb begin
    exp_full   = (model_q.size() == cb_depth);
    m_head     = (model_q.size() > 0) ? model_q[0] : '0;
    exp_cvalid = (model_q.size() > 0) && m_done[m_head.idx];
    exp_trap   = exp_cvalid && (m_exc[m_head.idx] != '0);
    // interrupt is refused while an exception commits
    exp_intr   = intr && !exp_trap;
    exp_flush  = exp_trap || exp_intr;
    exp_stall  = req.valid && ((reads_reg(req.src_a_sel) && m_busy[req.rs1]) ||
                 (reads_reg(req.src_b_sel) && m_busy[req.rs2]) ||
                 (req.wen && m_busy[req.rd]) || exp_full || (req.is_ls && busy_ls));
    exp_fire   = req.valid && !exp_stall;
    exp_npc    = (jump || (branch && mispredict)) && !exp_flush;
    exp_ifid   = exp_npc || exp_flush;
  end

  // model update on the edge
  // the pre-edge expectations are captured before any model state moves
  always @(posedge clk) begin
    logic       flush_now;
    logic       commit_now;
    logic       fire_now;
    model_ent_t head_now;
    flush_now  = exp_flush;
    commit_now = exp_cvalid;
    fire_now   = exp_fire;
    head_now   = m_head;
    if (!rst_n || flush_now) begin
      model_q.delete();
      m_busy = '0;
      m_done = '0;
      m_tail = '0;
    end else begin
      if (commit_now) begin
        if (head_now.wen && head_now.rd != '0) m_busy[head_now.rd] = 1'b0;
        m_done[head_now.idx] = 1'b0;
        void'(model_q.pop_front());
      end
      if (wb.valid) begin
        m_done[wb.cb_idx] = 1'b1;
        m_exc[wb.cb_idx]  = wb.exc;
        // instruction side faults report the fetch address
        m_bad[wb.cb_idx]  = (wb.exc.fault_insn || wb.exc.mal_insn) ? wb.badaddr_i : wb.badaddr_d;
      end
      if (fire_now) begin
        model_q.push_back('{pc: req.pc, rd: req.rd, wen: req.wen, idx: m_tail});
        if (req.wen && req.rd != '0) m_busy[req.rd] = 1'b1;
        m_tail = m_tail + 1'b1;
      end
    end
  end

  // checks against the model on each rising edge
  a_fire: assert property (@(posedge clk) disable iff (!rst_n) dispatch_fire == exp_fire)
    else report_mismatch("dispatch_fire", $sampled(exp_fire), $sampled(dispatch_fire));
  a_stall: assert property (@(posedge clk) disable iff (!rst_n) fetch.stall_de == exp_stall)
    else report_mismatch("fetch.stall_de", $sampled(exp_stall), $sampled(fetch.stall_de));
  a_pc_en: assert property (@(posedge clk) disable iff (!rst_n) fetch.pc_en == !exp_stall)
    else report_mismatch("fetch.pc_en", $sampled(!exp_stall), $sampled(fetch.pc_en));
  a_npc: assert property (@(posedge clk) disable iff (!rst_n) fetch.npc_sel == exp_npc)
    else report_mismatch("fetch.npc_sel", $sampled(exp_npc), $sampled(fetch.npc_sel));
  a_ifid: assert property (@(posedge clk) disable iff (!rst_n) fetch.if_id_flush == exp_ifid)
    else report_mismatch("fetch.if_id_flush", $sampled(exp_ifid), $sampled(fetch.if_id_flush));
  a_idx: assert property (@(posedge clk) disable iff (!rst_n)
    dispatch_fire |-> dispatch_idx == m_tail)
    else report_mismatch("dispatch_idx", $sampled(m_tail), $sampled(dispatch_idx));
  a_cvalid: assert property (@(posedge clk) disable iff (!rst_n) commit.valid == exp_cvalid)
    else report_mismatch("commit.valid", $sampled(exp_cvalid), $sampled(commit.valid));
  // commits follow program order from the head of the model queue
  a_cpc: assert property (@(posedge clk) disable iff (!rst_n)
    commit.valid |-> commit.pc == m_head.pc)
    else report_mismatch("commit.pc", $sampled(m_head.pc), $sampled(commit.pc));
  a_crd: assert property (@(posedge clk) disable iff (!rst_n)
    commit.valid |-> commit.rd == m_head.rd)
    else report_mismatch("commit.rd", $sampled(m_head.rd), $sampled(commit.rd));
  a_cwen: assert property (@(posedge clk) disable iff (!rst_n)
    commit.valid |-> commit.wen == m_head.wen)
    else report_mismatch("commit.wen", $sampled(m_head.wen), $sampled(commit.wen));
  a_cexc: assert property (@(posedge clk) disable iff (!rst_n)
    commit.valid |-> commit.exc == m_exc[m_head.idx])
    else report_mismatch("commit.exc", $sampled(m_exc[m_head.idx]), $sampled(commit.exc));
  a_cbad: assert property (@(posedge clk) disable iff (!rst_n)
    commit.valid |-> commit.badaddr == m_bad[m_head.idx])
    else report_mismatch("commit.badaddr", $sampled(m_bad[m_head.idx]), $sampled(commit.badaddr));
  a_trap: assert property (@(posedge clk) disable iff (!rst_n) priv.trap == exp_trap)
    else report_mismatch("priv.trap", $sampled(exp_trap), $sampled(priv.trap));
  a_epc: assert property (@(posedge clk) disable iff (!rst_n)
    priv.trap |-> priv.epc == m_head.pc)
    else report_mismatch("priv.epc", $sampled(m_head.pc), $sampled(priv.epc));
  a_pexc: assert property (@(posedge clk) disable iff (!rst_n)
    priv.trap |-> priv.exc == m_exc[m_head.idx])
    else report_mismatch("priv.exc", $sampled(m_exc[m_head.idx]), $sampled(priv.exc));
  a_bad: assert property (@(posedge clk) disable iff (!rst_n)
    priv.trap |-> priv.badaddr == m_bad[m_head.idx])
    else report_mismatch("priv.badaddr", $sampled(m_bad[m_head.idx]), $sampled(priv.badaddr));
  a_intr: assert property (@(posedge clk) disable iff (!rst_n) priv.intr_taken == exp_intr)
    else report_mismatch("priv.intr_taken", $sampled(exp_intr), $sampled(priv.intr_taken));

  function automatic decode_req_t build_req(input logic [xlen-1:0] pc, input int rs1, input int rs2,
                                            input int rd, input logic wen, input src_sel_t sa,
                                            input src_sel_t sb, input logic is_ls);
    decode_req_t r;
    r = '{valid: 1'b1, rs1: rs1[reg_w-1:0], rs2: rs2[reg_w-1:0], rd: rd[reg_w-1:0], wen: wen,
          src_a_sel: sa, src_b_sel: sb, is_ls: is_ls, pc: pc};
    return r;
  endfunction

  // wait n rising edges and then the drive offset
  task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // offer a request and wait for its fire strobe at mid cycle
  task automatic dispatch_req(input decode_req_t r, input int max_wait,
                              output logic [cb_idx_w-1:0] idx);
    int   waited;
    logic fired;
    waited = 0;
    fired  = 1'b0;
    req    = r;
    while (!fired) begin
      @(negedge clk);
      if (dispatch_fire) begin
        fired = 1'b1;
        idx   = dispatch_idx;
      end
      tick(1);
      waited++;
      if (!fired && waited >= max_wait) abort_run("dispatch did not fire in time");
    end
    req = '0;
  endtask

  // hold a request that is expected to stall
  task automatic hold_req(input decode_req_t r, input int n);
    req = r;
    tick(n);
    req = '0;
  endtask

  task automatic write_back(input logic [cb_idx_w-1:0] idx, input exc_flags_t e,
                            input logic [xlen-1:0] bi, input logic [xlen-1:0] bd);
    wb = '{valid: 1'b1, cb_idx: idx, exc: e, badaddr_i: bi, badaddr_d: bd};
    tick(1);
    wb = '0;
  endtask

  // wait until every dispatched entry has committed
  task automatic drain(input int max_wait);
    int waited;
    waited = 0;
    while (model_q.size() != 0) begin
      tick(1);
      waited++;
      if (waited > max_wait) abort_run("completion buffer did not drain in time");
    end
  endtask

  initial begin
    #(t_total * 10);
    abort_run("watchdog timeout, the run did not finish");
  end

  initial begin
    logic [cb_idx_w-1:0] ia;
    logic [cb_idx_w-1:0] ib;
    exc_flags_t          e;
    int                  j;
    int                  tmp;
    void'($urandom(77304));
    clk        = 1'b0;
    rst_n      = 1'b0;
    req        = '0;
    wb         = '0;
    busy_ls    = 1'b0;
    jump       = 1'b0;
    branch     = 1'b0;
    mispredict = 1'b0;
    intr       = 1'b0;
    tick(8);
    rst_n = 1'b1;
    // idle window after reset with every control output inactive
    tick(3);

    // r5 writer and then a reader of r5 that must wait
    dispatch_req(build_req(32'h100, 0, 0, 5, 1'b1, src_imm, src_imm, 1'b0), 2, ia);
    hold_req(build_req(32'h104, 5, 0, 0, 1'b0, rs_reg, src_imm, 1'b0), 4);
    // same operands as immediates go at once
    dispatch_req(build_req(32'h108, 5, 5, 0, 1'b0, src_imm, src_pc, 1'b0), 1, ib);
    // second writer of r5 stalls on rd
    hold_req(build_req(32'h10c, 0, 0, 5, 1'b1, src_imm, src_imm, 1'b0), 3);
    write_back(ia, '0, '0, '0);
    dispatch_req(build_req(32'h110, 0, 5, 0, 1'b0, src_imm, rs_fwd, 1'b0), 4, ia);
    write_back(ib, '0, '0, '0);
    write_back(ia, '0, '0, '0);
    drain(10);

    // fill the buffer and complete it in shuffled order
    for (int i = 0; i < cb_depth; i++) begin
      dispatch_req(build_req(32'h200 + 4 * i, 0, 0, i + 1, 1'b1, src_imm, src_imm, 1'b0), 2,
                   fill_idx[i]);
      order[i] = i;
    end
    hold_req(build_req(32'h240, 0, 0, 0, 1'b0, src_imm, src_imm, 1'b0), 4);
    for (int i = cb_depth - 1; i > 0; i--) begin
      j        = $urandom_range(i, 0);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < cb_depth; i++) begin
      write_back(fill_idx[order[i]], '0, '0, '0);
    end
    drain(20);

    // memory op waits for the load-store unit
    busy_ls = 1'b1;
    hold_req(build_req(32'h300, 1, 0, 0, 1'b0, rs_reg, src_imm, 1'b1), 3);
    busy_ls = 1'b0;
    dispatch_req(build_req(32'h300, 1, 0, 0, 1'b0, rs_reg, src_imm, 1'b1), 2, ia);
    write_back(ia, '0, '0, '0);
    drain(10);

    // fetch fault at the head takes badaddr from the instruction side
    dispatch_req(build_req(32'h400, 0, 0, 7, 1'b1, src_imm, src_imm, 1'b0), 2, ia);
    dispatch_req(build_req(32'h404, 0, 0, 8, 1'b1, src_imm, src_imm, 1'b0), 2, ib);
    e            = '0;
    e.fault_insn = 1'b1;
    write_back(ia, e, 32'h400, 32'hdead_0000);
    // the flush of the trap cycle lands on the next edge
    tick(1);
    dispatch_req(build_req(32'h408, 7, 8, 8, 1'b1, rs_reg, rs_reg, 1'b0), 1, ia);
    write_back(ia, '0, '0, '0);
    drain(10);

    // random interrupt and redirect traffic
    for (int i = 0; i < 50; i++) begin
      intr       = ($urandom_range(3, 0) == 0);
      jump       = ($urandom_range(1, 0) == 1);
      branch     = ($urandom_range(1, 0) == 1);
      mispredict = ($urandom_range(1, 0) == 1);
      tick(1);
    end
    intr       = 1'b0;
    jump       = 1'b0;
    branch     = 1'b0;
    mispredict = 1'b0;

    // illegal op commits while intr and jump are raised
    dispatch_req(build_req(32'h500, 0, 0, 9, 1'b1, src_imm, src_imm, 1'b0), 2, ia);
    e              = '0;
    e.illegal_insn = 1'b1;
    write_back(ia, e, 32'h500, 32'h0000_bad0);
    intr = 1'b1;
    jump = 1'b1;
    tick(1);
    intr = 1'b0;
    jump = 1'b0;
    tick(4);

    $display("All tests passed!");
    $finish;
  end

endmodule

/* list.f */
logic/hazard_pkg.sv
logic/reg_scoreboard.sv
logic/completion_buffer.sv
logic/ooo_hazard_unit.sv
logic/ooo_hazard_top.sv
bench/hazard_tb.sv

/* Bender.yml */
package:
  name: ooo_hazard

sources:
  - logic/hazard_pkg.sv
  - logic/reg_scoreboard.sv
  - logic/completion_buffer.sv
  - logic/ooo_hazard_unit.sv
  - logic/ooo_hazard_top.sv
  - target: test
    files:
      - bench/hazard_tb.sv
